//--- hdl/addressDecode.sv
`timescale 1ns/1ps

module addressDecode (
    input  logic        rstN,
    input  logic [31:12] a,
    input  logic        ts,
    input  logic [1:0]  tt,
    input  logic        ovl,
    input  logic        ciaEnable,
    output logic        romEn,
    output logic        ciaSpace,
    output logic        ciaCs0N,
    output logic        ciaCs1N,
    output logic        ramSpaceN,
    output logic        regSpaceN,
    output logic        autoVector
);

    import gluePkg::*;

    logic zorroSpace;
    logic romLowHit;
    logic romHighHit;
    logic ciaHit;
    logic regHit;

    ////////////////////////////////////////
    // Zorro II qualifier
    ////////////////////////////////////////

    // Everything below lives in the low 16 MB
    // Keeps us off cycles meant for other spaces
    assign zorroSpace = (a[31:24] == zorroHiByte);

    // Region hits inside the 24-bit space
    assign romLowHit  = zorroSpace && (a[23:21] == romLowSel);
    assign romHighHit = zorroSpace && (a[23:19] == romHighSel);
    assign ciaHit     = zorroSpace && (a[23:16] == ciaPage);
    assign regHit     = zorroSpace && (a[23:16] == regPage);

    ////////////////////////////////////////
    // ROM
    ////////////////////////////////////////

    // High ROM always decodes
    // Low region only while overlay is set, for the reset vector fetch
    assign romEn = rstN && (romHighHit || (ovl && romLowHit));

    ////////////////////////////////////////
    // CIA
    ////////////////////////////////////////

    assign ciaSpace = rstN && ciaHit;

    // Selects follow the E window from the sequencer
    // A12 low picks CIA0, A13 low picks CIA1
    assign ciaCs0N = !(ciaEnable && !a[12]);
    assign ciaCs1N = !(ciaEnable && !a[13]);

    ////////////////////////////////////////
    // Chipset spaces
    ////////////////////////////////////////

    // Handed to the chipset, qualified by TS
    // Chip RAM only once overlay is off
    assign ramSpaceN = !(romLowHit && !ovl && ts);
    assign regSpaceN = !(regHit && ts);

    ////////////////////////////////////////
    // Autovector
    ////////////////////////////////////////

    // IACK cycle on the all-ones page, always autovectored
    assign autoVector = rstN && (tt == ttIntAck) && (a[31:16] == avecPage);

endmodule

//--- hdl/ciaCycle.sv
`timescale 1ns/1ps

module ciaCycle (
    input  logic clk40,
    input  logic rstN,
    input  logic ciaSpace,
    input  logic ts,
    output logic eClock,
    output logic ciaEnable,
    output logic ciaAck
);

    import gluePkg::*;

    logic [3:0] divCnt;
    logic [3:0] divNext;
    logic       eClkNext;
    ciaStateT   state;
    ciaStateT   stateNext;

    ////////////////////////////////////////
    // E clock divider
    ////////////////////////////////////////

    // Free running count 0 to eClkDiv-1
    always_comb begin
        if (divCnt == eClkDiv - 4'd1) begin
            divNext = 4'd0;
        end else begin
            divNext = divCnt + 4'd1;
        end
    end

    // Level E takes after the next edge
    // Lets the FSM line up with E exactly
    assign eClkNext = (divNext >= eClkHighStart);

    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            divCnt <= 4'd0;
            eClock <= 1'b0;
        end else begin
            divCnt <= divNext;
            eClock <= eClkNext;
        end
    end

    ////////////////////////////////////////
    // Access sequencer
    ////////////////////////////////////////

    always_comb begin
        stateNext = state;
        case (state)
            // Request taken on TS in CIA space
            ciaIdle: begin
                if (ts && ciaSpace) begin
                    stateNext = ciaSyncLow;
                end
            end
            // Let any high phase in progress finish
            ciaSyncLow: begin
                if (!eClkNext) begin
                    stateNext = ciaWaitHigh;
                end
            end
            // E low here, wait for the rise
            ciaWaitHigh: begin
                if (eClkNext) begin
                    stateNext = ciaActive;
                end
            end
            // Chip selects open for the whole high phase
            ciaActive: begin
                if (!eClkNext) begin
                    stateNext = ciaDone;
                end
            end
            // One cycle to report the end
            ciaDone: begin
                stateNext = ciaIdle;
            end
            default: begin
                stateNext = ciaIdle;
            end
        endcase
    end

    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            state <= ciaIdle;
        end else begin
            state <= stateNext;
        end
    end

    // Registered from next state, so aligned with E itself
    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            ciaEnable <= 1'b0;
            ciaAck    <= 1'b0;
        end else begin
            ciaEnable <= (stateNext == ciaActive);
            ciaAck    <= (stateNext == ciaDone);
        end
    end

endmodule

//--- hdl/cycleTerminator.sv
`timescale 1ns/1ps

module cycleTerminator (
    input  logic clk40,
    input  logic rstN,
    input  logic ts,
    input  logic romEn,
    input  logic autoVector,
    input  logic ciaAck,
    output logic taN,
    output logic avecN
);

    import gluePkg::*;

    termStateT  state;
    termStateT  stateNext;
    logic [2:0] waitCnt;
    logic       avecHit;

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    always_comb begin
        stateNext = state;
        case (state)
            termIdle: begin
                // Autovector needs no wait states
                if (ts && autoVector) begin
                    stateNext = termAck;
                end else if (ts && romEn) begin
                    stateNext = termRomWait;
                end
            end
            // Count down the ROM access time
            termRomWait: begin
                if (waitCnt == 3'd1) begin
                    stateNext = termAck;
                end
            end
            termAck: begin
                stateNext = termIdle;
            end
            default: begin
                stateNext = termIdle;
            end
        endcase

        // End of a CIA access wins over anything else
        if (ciaAck) begin
            stateNext = termAck;
        end
    end

    ////////////////////////////////////////
    // State, wait counter, IACK flag
    ////////////////////////////////////////

    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            state   <= termIdle;
            waitCnt <= 3'd0;
            avecHit <= 1'b0;
        end else begin
            state <= stateNext;

            // Loaded on TS, one count per clock after
            if (state == termIdle && ts) begin
                waitCnt <= romWaitCycles;
            end else if (state == termRomWait) begin
                waitCnt <= waitCnt - 3'd1;
            end

            // Remember whether this cycle is an IACK
            if (state == termIdle && ts) begin
                avecHit <= autoVector;
            end else if (state == termAck) begin
                avecHit <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Termination pulses
    ////////////////////////////////////////

    // One clock low in the cycle after the ack state
    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            taN   <= 1'b1;
            avecN <= 1'b1;
        end else begin
            taN   <= !(state == termAck);
            avecN <= !(state == termAck && avecHit);
        end
    end

endmodule

//--- hdl/gluePkg.sv
package gluePkg;

    ////////////////////////////////////////
    // Address regions
    ////////////////////////////////////////

    // Top byte of the 24-bit Zorro II space
    localparam logic [7:0] zorroHiByte = 8'h00;

    // Boot overlay region, A[23:21] all zero
    localparam logic [2:0] romLowSel = 3'b000;

    // Kickstart ROM $F80000 to $FFFFFF, A[23:19] all ones
    localparam logic [4:0] romHighSel = 5'b11111;

    // CIA page at $BFxxxx
    localparam logic [7:0] ciaPage = 8'hBF;

    // Custom chip registers at $DFxxxx
    localparam logic [7:0] regPage = 8'hDF;

    // Interrupt acknowledge page, A[31:16] all ones
    localparam logic [15:0] avecPage = 16'hFFFF;

    ////////////////////////////////////////
    // Timing
    ////////////////////////////////////////

    // clk40 cycles per E clock period
    localparam logic [3:0] eClkDiv = 4'd10;

    // Divider count where E goes high
    // 6 low then 4 high
    localparam logic [3:0] eClkHighStart = 4'd6;

    // ROM wait states before TA
    localparam logic [2:0] romWaitCycles = 3'd4;

    // Transfer type of an interrupt acknowledge
    localparam logic [1:0] ttIntAck = 2'b11;

    ////////////////////////////////////////
    // State encodings
    ////////////////////////////////////////

    // CIA sequencer
    typedef enum logic [2:0] {
        ciaIdle,
        ciaSyncLow,
        ciaWaitHigh,
        ciaActive,
        ciaDone
    } ciaStateT;

    // Cycle terminator
    typedef enum logic [1:0] {
        termIdle,
        termRomWait,
        termAck
    } termStateT;

endpackage

//--- hdl/glueTop.sv
`timescale 1ns/1ps

module glueTop (
    input  logic        clk40,
    input  logic        rstN,
    input  logic [31:12] a,
    input  logic        ts,
    input  logic [1:0]  tt,
    input  logic        ovl,
    output logic        romEn,
    output logic        ciaSpace,
    output logic        ciaCs0N,
    output logic        ciaCs1N,
    output logic        ramSpaceN,
    output logic        regSpaceN,
    output logic        eClock,
    output logic        taN,
    output logic        avecN
);

    // Internal handoffs between the blocks
    logic autoVector;
    logic ciaEnable;
    logic ciaAck;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    addressDecode decodeInst (
        .rstN      (rstN),
        .a         (a),
        .ts        (ts),
        .tt        (tt),
        .ovl       (ovl),
        .ciaEnable (ciaEnable),
        .romEn     (romEn),
        .ciaSpace  (ciaSpace),
        .ciaCs0N   (ciaCs0N),
        .ciaCs1N   (ciaCs1N),
        .ramSpaceN (ramSpaceN),
        .regSpaceN (regSpaceN),
        .autoVector(autoVector)
    );

    // E clock and CIA window
    ciaCycle ciaInst (
        .clk40    (clk40),
        .rstN     (rstN),
        .ciaSpace (ciaSpace),
        .ts       (ts),
        .eClock   (eClock),
        .ciaEnable(ciaEnable),
        .ciaAck   (ciaAck)
    );

    // TA and AVEC toward the CPU
    cycleTerminator termInst (
        .clk40     (clk40),
        .rstN      (rstN),
        .ts        (ts),
        .romEn     (romEn),
        .autoVector(autoVector),
        .ciaAck    (ciaAck),
        .taN       (taN),
        .avecN     (avecN)
    );

endmodule

//--- sim.f
hdl/gluePkg.sv
hdl/addressDecode.sv
hdl/ciaCycle.sv
hdl/cycleTerminator.sv
hdl/glueTop.sv
verif/glueTb.sv

//--- verif/glueTb.sv
`timescale 1ns/1ps

module glueTb;

    import gluePkg::*;

    localparam int clkPeriod = 4;
    localparam int waitLimit = 40;

    logic        clk40;
    logic        rstN;
    logic [31:12] a;
    logic        ts;
    logic [1:0]  tt;
    logic        ovl;
    logic        romEn;
    logic        ciaSpace;
    logic        ciaCs0N;
    logic        ciaCs1N;
    logic        ramSpaceN;
    logic        regSpaceN;
    logic        eClock;
    logic        taN;
    logic        avecN;

    integer seed;
    int     valueErrors;
    int     timeoutErrors;

    glueTop uut (
        .clk40    (clk40),
        .rstN     (rstN),
        .a        (a),
        .ts       (ts),
        .tt       (tt),
        .ovl      (ovl),
        .romEn    (romEn),
        .ciaSpace (ciaSpace),
        .ciaCs0N  (ciaCs0N),
        .ciaCs1N  (ciaCs1N),
        .ramSpaceN(ramSpaceN),
        .regSpaceN(regSpaceN),
        .eClock   (eClock),
        .taN      (taN),
        .avecN    (avecN)
    );

    initial begin
        clk40 = 1'b0;
        forever #(clkPeriod / 2) clk40 = ~clk40;
    end

    ////////////////////////////////////////
    // Compare and report helpers
    ////////////////////////////////////////

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error %s got %h expected %h", name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkCycles(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Error %s got %0h expected %0h", name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic noteTimeout(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, waitLimit);
        timeoutErrors++;
    endtask

    // Region rules written as address ranges
    task automatic expectedRegions(input logic [31:0] addr, input logic ovlIn,
                                   output logic expRom, output logic expCia,
                                   output logic expRamN, output logic expRegN);
        logic        low16M;
        logic [23:0] off;
        low16M  = (addr[31:24] == 8'h00);
        off     = addr[23:0];
        expRom  = low16M && ((off >= 24'hF80000) || (ovlIn && off < 24'h200000));
        expCia  = low16M && (off >= 24'hBF0000) && (off <= 24'hBFFFFF);
        // ts is high whenever these are checked
        expRamN = !(low16M && !ovlIn && off < 24'h200000);
        expRegN = !(low16M && (off >= 24'hDF0000) && (off <= 24'hDFFFFF));
    endtask

    ////////////////////////////////////////
    // Bus cycle helpers
    ////////////////////////////////////////

    // ts high across exactly one rising edge
    task automatic issueCycle(input logic [31:0] addr, input logic [1:0] ttVal);
        @(negedge clk40);
        a  = addr[31:12];
        tt = ttVal;
        ts = 1'b1;
        @(negedge clk40);
        ts = 1'b0;
    endtask

    // Falling edges until taN is seen low
    task automatic waitTaLow(output int cycles, output logic seen);
        int n;
        cycles = 0;
        seen   = 1'b0;
        for (n = 0; n < waitLimit && !seen; n++) begin
            @(negedge clk40);
            cycles++;
            if (!taN) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            noteTimeout("taN low after ts");
        end
    endtask

    task automatic countTaLow(input int span, output int lowCount);
        int n;
        lowCount = 0;
        for (n = 0; n < span; n++) begin
            @(negedge clk40);
            if (!taN || !avecN) begin
                lowCount++;
            end
        end
    endtask

    task automatic restartDut;
        @(negedge clk40);
        ts   = 1'b0;
        ovl  = 1'b0;
        rstN = 1'b0;
        repeat (3) @(negedge clk40);
        rstN = 1'b1;
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    // Runs inside the initial 3-cycle reset
    task automatic resetGating;
        @(negedge clk40);
        a   = 20'h00F80;
        ovl = 1'b1;
        ts  = 1'b1;
        tt  = ttIntAck;
        #1;
        checkBit("romEn", romEn, 1'b0);
        checkBit("taN", taN, 1'b1);
        checkBit("avecN", avecN, 1'b1);
        @(negedge clk40);
        a = 20'h00BFE;
        #1;
        checkBit("ciaSpace", ciaSpace, 1'b0);
        checkBit("taN", taN, 1'b1);
        @(negedge clk40);
        checkBit("taN", taN, 1'b1);
        checkBit("avecN", avecN, 1'b1);
        ts   = 1'b0;
        tt   = 2'b00;
        a    = '0;
        rstN = 1'b1;
    endtask

    task automatic decodeRegions;
        logic [31:0] corners [14];
        logic [31:0] addr;
        logic [31:0] rnd;
        logic        expRom;
        logic        expCia;
        logic        expRamN;
        logic        expRegN;
        int          o;
        int          i;
        corners = '{32'h00000000, 32'h001FF000, 32'h00200000, 32'h00F7F000,
                    32'h00F80000, 32'h00FFF000, 32'h00BF0000, 32'h00BFF000,
                    32'h00BEF000, 32'h00C00000, 32'h00DF0000, 32'h00DFF000,
                    32'h01F80000, 32'hFFFFF000};
        for (o = 0; o < 2; o++) begin
            for (i = 0; i < 14 + 24; i++) begin
                if (i < 14) begin
                    addr = corners[i];
                end else begin
                    rnd  = $random(seed);
                    // Mostly inside the 24-bit space
                    addr = (rnd[31:28] == 4'h0) ? rnd : {8'h00, rnd[23:0]};
                end
                @(negedge clk40);
                a   = addr[31:12];
                ovl = o[0];
                tt  = 2'b00;
                ts  = 1'b1;
                #1;
                expectedRegions(addr, o[0], expRom, expCia, expRamN, expRegN);
                checkBit("romEn", romEn, expRom);
                checkBit("ciaSpace", ciaSpace, expCia);
                checkBit("ramSpaceN", ramSpaceN, expRamN);
                checkBit("regSpaceN", regSpaceN, expRegN);
            end
        end
        @(negedge clk40);
        ts = 1'b0;
    endtask

    task automatic autovectorAck;
        int   cycles;
        int   lowCount;
        logic seen;
        issueCycle(32'hFFFFF000, ttIntAck);
        waitTaLow(cycles, seen);
        if (seen) begin
            checkCycles("taN delay", cycles, 1);
            checkBit("avecN", avecN, 1'b0);
            @(negedge clk40);
            checkBit("taN", taN, 1'b1);
            checkBit("avecN", avecN, 1'b1);
        end
        a  = '0;
        tt = 2'b00;
        // Same page, not an interrupt acknowledge
        issueCycle(32'hFFFFF000, 2'b10);
        countTaLow(20, lowCount);
        checkCycles("taN low cycles", lowCount, 0);
        a  = '0;
        tt = 2'b00;
    endtask

    task automatic romTermination;
        logic [31:0] rnd;
        int          cycles;
        logic        seen;
        rnd = $random(seed);
        issueCycle({8'h00, 5'b11111, rnd[18:0]}, 2'b00);
        waitTaLow(cycles, seen);
        if (seen) begin
            checkCycles("taN delay", cycles, romWaitCycles + 1);
            checkBit("avecN", avecN, 1'b1);
            @(negedge clk40);
            checkBit("taN", taN, 1'b1);
        end
        a = '0;
    endtask

    task automatic eClockTiming;
        int   n;
        int   highCycles;
        int   lowCycles;
        logic prev;
        logic done;
        prev = eClock;
        done = 1'b0;
        for (n = 0; n < waitLimit && !done; n++) begin
            @(negedge clk40);
            done = eClock && !prev;
            prev = eClock;
        end
        if (!done) begin
            noteTimeout("eClock rising edge");
        end else begin
            highCycles = 1;
            done = 1'b0;
            for (n = 0; n < waitLimit && !done; n++) begin
                @(negedge clk40);
                if (eClock) begin
                    highCycles++;
                end else begin
                    done = 1'b1;
                end
            end
            if (!done) begin
                noteTimeout("eClock falling edge");
            end else begin
                lowCycles = 1;
                done = 1'b0;
                for (n = 0; n < waitLimit && !done; n++) begin
                    @(negedge clk40);
                    if (!eClock) begin
                        lowCycles++;
                    end else begin
                        done = 1'b1;
                    end
                end
                if (!done) begin
                    noteTimeout("eClock rising edge after the low phase");
                end else begin
                    checkCycles("eClock high cycles", highCycles,
                                eClkDiv - eClkHighStart);
                    checkCycles("eClock period", highCycles + lowCycles, eClkDiv);
                end
            end
        end
    endtask

    // sel0 and sel1 say which CIA the address picks
    task automatic ciaAccess(input logic [31:0] addr, input logic sel0, input logic sel1);
        int   n;
        int   cs0Low;
        int   cs1Low;
        int   outside;
        logic seen;
        cs0Low  = 0;
        cs1Low  = 0;
        outside = 0;
        seen    = 1'b0;
        issueCycle(addr, 2'b00);
        for (n = 0; n < waitLimit && !seen; n++) begin
            @(negedge clk40);
            if (!ciaCs0N) cs0Low++;
            if (!ciaCs1N) cs1Low++;
            // Selects only inside the E high phase
            if ((!ciaCs0N || !ciaCs1N) && !eClock) begin
                outside++;
            end
            if (!taN) begin
                seen = 1'b1;
                checkBit("eClock", eClock, 1'b0);
            end
        end
        if (!seen) begin
            noteTimeout("taN low after a CIA access");
        end else begin
            checkCycles("ciaCs0N low cycles", cs0Low, sel0 ? 4 : 0);
            checkCycles("ciaCs1N low cycles", cs1Low, sel1 ? 4 : 0);
            checkCycles("select cycles with eClock low", outside, 0);
            checkBit("avecN", avecN, 1'b1);
            @(negedge clk40);
            checkBit("taN", taN, 1'b1);
        end
        a = '0;
    endtask

    // Chipset ends these cycles, so taN stays high
    task automatic chipsetNoAck;
        int lowCount;
        issueCycle(32'h00012000, 2'b00);
        countTaLow(20, lowCount);
        checkCycles("taN low cycles after RAM access", lowCount, 0);
        // Chip RAM address held with ts low
        checkBit("ramSpaceN", ramSpaceN, 1'b1);
        issueCycle(32'h00DFF000, 2'b00);
        countTaLow(20, lowCount);
        checkCycles("taN low cycles after register access", lowCount, 0);
        // Register page held with ts low
        checkBit("regSpaceN", regSpaceN, 1'b1);
        a = '0;
    endtask

    ////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////

    initial begin
        rstN          = 1'b0;
        a             = '0;
        ts            = 1'b0;
        tt            = 2'b00;
        ovl           = 1'b1;
        seed          = 32'h0cf94b0c;
        valueErrors   = 0;
        timeoutErrors = 0;

        resetGating();
        decodeRegions();
        // Decode run leaves FSMs mid-cycle
        restartDut();
        autovectorAck();
        romTermination();
        eClockTiming();
        ciaAccess(32'h00BFE000, 1'b1, 1'b0);
        ciaAccess(32'h00BFD000, 1'b0, 1'b1);
        chipsetNoAck();
        @(negedge clk40);

        $display("Summary: %0d value errors, %0d timeouts", valueErrors, timeoutErrors);
        if (valueErrors == 0 && timeoutErrors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
